// ==== if_fetch.f ====
hw/if_cfg_pkg.sv
hw/if_ctrl_pkg.sv
hw/fetch_if.sv
hw/fetch_requester.sv
hw/instr_buffer.sv
hw/if_id_stage.sv
hw/if_stage.sv
verif/tb_clk_gen.sv
verif/tb_instr_mem.sv
verif/tb_if_stage.sv

// ==== verif/tb_if_stage.sv ====
// Fetch stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  logic                 clk;
  logic                 rst_n;
  logic                 pc_set;
  if_ctrl_pkg::pc_mux_e pc_mux;
  logic                 kill_if;
  logic                 halt_if;
  logic                 id_ready;
  if_cfg_pkg::addr_t    boot_addr;
  if_cfg_pkg::addr_t    jump_target;
  if_cfg_pkg::addr_t    branch_target;
  if_cfg_pkg::addr_t    mepc;
  if_cfg_pkg::addr_t    dpc;
  if_cfg_pkg::addr_t    dm_halt_addr;
  if_cfg_pkg::addr_t    dm_exc_addr;
  if_cfg_pkg::mtvec_t   mtvec_addr;
  if_cfg_pkg::irq_id_t  irq_id;
  logic                 instr_req;
  if_cfg_pkg::addr_t    instr_addr;
  logic                 instr_gnt;
  logic                 instr_rvalid;
  if_cfg_pkg::instr_t   instr_rdata;
  logic                 instr_err;
  logic                 instr_valid;
  if_cfg_pkg::addr_t    instr_pc;
  if_cfg_pkg::instr_t   instr_word;
  logic                 abort;
  logic                 if_busy;
  logic                 mtvec_init;

  // Scoreboard and bookkeeping
  string                test_name;
  int                   err_cnt;
  int                   test_err_base;
  int                   pass_cnt;
  int                   fail_cnt;
  int                   accepted;
  int                   outstanding;
  logic                 started;
  logic                 kill_d;
  logic                 stall_d;
  logic                 req_wait_d;
  if_cfg_pkg::addr_t    req_addr_d;
  if_cfg_pkg::addr_t    exp_pc;
  if_cfg_pkg::addr_t    held_pc;
  if_cfg_pkg::instr_t   held_instr;
  logic [31:0]          lfsr;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  if_stage u_dut (
    .clk (clk), .rst_n (rst_n),
    .pc_set_i (pc_set), .pc_mux_i (pc_mux), .kill_if_i (kill_if), .halt_if_i (halt_if),
    .boot_addr_i (boot_addr), .jump_target_i (jump_target), .branch_target_i (branch_target),
    .mepc_i (mepc), .dpc_i (dpc), .dm_halt_addr_i (dm_halt_addr),
    .dm_exception_addr_i (dm_exc_addr), .mtvec_addr_i (mtvec_addr), .irq_id_i (irq_id),
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata), .instr_err_i (instr_err),
    .id_ready_i (id_ready), .instr_valid_o (instr_valid), .instr_pc_o (instr_pc),
    .instr_o (instr_word), .abort_o (abort),
    .if_busy_o (if_busy), .csr_mtvec_init_o (mtvec_init)
  );

  tb_instr_mem u_mem (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req), .addr_i (instr_addr),
    .gnt_o (instr_gnt), .rvalid_o (instr_rvalid), .rdata_o (instr_rdata), .err_o (instr_err)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic rand_bit(output logic b);
    b = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  // Redirect target per source, word aligned
  function automatic if_cfg_pkg::addr_t expected_target(input if_ctrl_pkg::pc_mux_e m);
    if_cfg_pkg::addr_t base;
    if_cfg_pkg::addr_t t;
    base = {mtvec_addr, 7'h00};
    case (m)
      if_ctrl_pkg::PC_JUMP:     t = jump_target;
      if_ctrl_pkg::PC_BRANCH:   t = branch_target;
      if_ctrl_pkg::PC_MRET:     t = mepc;
      if_ctrl_pkg::PC_DRET:     t = dpc;
      if_ctrl_pkg::PC_TRAP_EXC: t = base;
      if_ctrl_pkg::PC_TRAP_IRQ: t = base + irq_id * 4;
      if_ctrl_pkg::PC_TRAP_NMI: t = base + if_cfg_pkg::NMI_INDEX * 4;
      if_ctrl_pkg::PC_TRAP_DBD: t = dm_halt_addr;
      if_ctrl_pkg::PC_TRAP_DBE: t = dm_exc_addr;
      default:                  t = boot_addr;
    endcase
    return {t[31:2], 2'b00};
  endfunction

  task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
    err_cnt++;
  endtask

  ////////////////////////////////////////
  // Checkers, on pre-edge values
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      // Quiet until the first redirect
      if (!started) begin
        assert (!instr_req) else fail_value("instr_req_o idle", 0, instr_req);
        assert (!instr_valid) else fail_value("instr_valid_o idle", 0, instr_valid);
        assert (!if_busy) else fail_value("if_busy_o idle", 0, if_busy);
      end
      assert (mtvec_init == (pc_set && pc_mux == if_ctrl_pkg::PC_BOOT))
        else fail_value("csr_mtvec_init_o", pc_set && pc_mux == if_ctrl_pkg::PC_BOOT, mtvec_init);
      assert (if_busy == (outstanding != 0))
        else fail_value("if_busy_o", outstanding != 0, if_busy);
      assert (outstanding + instr_req <= 2)
        else fail_value("fetches in flight", 2, outstanding + instr_req);
      // Bus requests are word aligned
      if (instr_req) begin
        assert (instr_addr[1:0] == 2'b00)
          else fail_value("instr_addr_o alignment", 0, instr_addr[1:0]);
      end
      // Ungranted request stays up with the same address
      if (req_wait_d) begin
        assert (instr_req) else fail_value("instr_req_o before grant", 1, instr_req);
        assert (instr_addr == req_addr_d)
          else fail_value("instr_addr_o before grant", req_addr_d, instr_addr);
      end
      if (kill_d) begin
        assert (!instr_valid) else fail_value("instr_valid_o after kill", 0, instr_valid);
      end
      // Decode stalled last cycle, IF/ID must hold
      if (stall_d) begin
        assert (instr_valid) else fail_value("instr_valid_o under stall", 1, instr_valid);
        assert (instr_pc == held_pc) else fail_value("instr_pc_o under stall", held_pc, instr_pc);
        assert (instr_word == held_instr)
          else fail_value("instr_o under stall", held_instr, instr_word);
      end
      // Decode takes an instruction, must be the next word of the stream
      if (instr_valid && id_ready && !kill_if && !pc_set) begin
        assert (instr_pc == exp_pc) else fail_value("instr_pc_o", exp_pc, instr_pc);
        assert (instr_word == (exp_pc ^ 32'h5a5a_0000))
          else fail_value("instr_o", exp_pc ^ 32'h5a5a_0000, instr_word);
        assert (abort == (exp_pc[31:28] == 4'he))
          else fail_value("abort_o", exp_pc[31:28] == 4'he, abort);
        exp_pc = exp_pc + 32'd4;
        accepted++;
      end
      if (pc_set) begin
        exp_pc  = expected_target(pc_mux);
        started = 1'b1;
      end
      outstanding = outstanding + (instr_req && instr_gnt) - instr_rvalid;
      kill_d      = kill_if;
      stall_d     = instr_valid && !id_ready && !kill_if && !pc_set;
      req_wait_d  = instr_req && !instr_gnt;
      req_addr_d  = instr_addr;
      held_pc     = instr_pc;
      held_instr  = instr_word;
    end
  end

  ////////////////////////////////////////
  // Stimulus, driven on falling edges
  ////////////////////////////////////////

  task automatic redirect(input if_ctrl_pkg::pc_mux_e m);
    pc_mux = m;
    pc_set = 1'b1;
    @(negedge clk);
    pc_set = 1'b0;
  endtask

  // Optional random decode stall and halt while waiting
  task automatic wait_accepts(input int n, input logic jitter);
    int   goal;
    int   cycles;
    logic b0;
    logic b1;
    goal   = accepted + n;
    cycles = 0;
    while (accepted < goal && cycles < 400) begin
      @(negedge clk);
      cycles++;
      if (jitter) begin
        rand_bit(b0);
        rand_bit(b1);
        id_ready = b0 | b1;
        rand_bit(b0);
        rand_bit(b1);
        halt_if = b0 & b1;
      end
    end
    id_ready = 1'b1;
    halt_if  = 1'b0;
    if (accepted < goal) begin
      $display("ERROR %s: timeout, instr_valid_o never delivered %0d instructions", test_name, n);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == test_err_base) begin
      $display("PASS %s", test_name);
      pass_cnt++;
    end else begin
      $display("FAIL %s: %0d errors", test_name, err_cnt - test_err_base);
      fail_cnt++;
    end
  endtask

  initial begin
    int cycles;
    pc_set        = 1'b0;
    pc_mux        = if_ctrl_pkg::PC_BOOT;
    kill_if       = 1'b0;
    halt_if       = 1'b0;
    id_ready      = 1'b1;
    boot_addr     = 32'h0000_1082;
    jump_target   = 32'h0000_2000;
    branch_target = 32'h0000_3104;
    mepc          = 32'h0000_4203;
    dpc           = 32'h0000_5008;
    dm_halt_addr  = 32'h1a10_0800;
    dm_exc_addr   = 32'h1a10_0808;
    mtvec_addr    = 25'h00_0060;
    irq_id        = 5'd11;
    lfsr          = 32'ha853fa9b;
    err_cnt       = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    accepted      = 0;
    outstanding   = 0;
    started       = 1'b0;
    kill_d        = 1'b0;
    stall_d       = 1'b0;
    req_wait_d    = 1'b0;

    begin_test("reset_idle");
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("ERROR %s: timeout, rst_n was never released", test_name);
      err_cnt++;
    end
    repeat (4) @(negedge clk);
    end_test();

    begin_test("boot_fetch");
    redirect(if_ctrl_pkg::PC_BOOT);
    wait_accepts(8, 1'b0);
    end_test();

    // Back to back redirects leave responses in flight
    begin_test("redirect_targets");
    for (int i = 0; i < 10; i++) begin
      redirect(if_ctrl_pkg::pc_mux_e'(i));
      wait_accepts(3, 1'b0);
    end
    end_test();

    begin_test("back_pressure");
    redirect(if_ctrl_pkg::PC_JUMP);
    wait_accepts(20, 1'b1);
    end_test();

    // Walk into and out of the error region
    begin_test("bus_error");
    jump_target = 32'hdfff_fff8;
    redirect(if_ctrl_pkg::PC_JUMP);
    wait_accepts(4, 1'b0);
    jump_target = 32'hefff_fff8;
    redirect(if_ctrl_pkg::PC_JUMP);
    wait_accepts(4, 1'b0);
    end_test();

    begin_test("kill");
    jump_target = 32'h0000_2400;
    redirect(if_ctrl_pkg::PC_JUMP);
    wait_accepts(2, 1'b0);
    kill_if = 1'b1;
    repeat (4) @(negedge clk);
    kill_if = 1'b0;
    redirect(if_ctrl_pkg::PC_BRANCH);
    wait_accepts(3, 1'b0);
    end_test();

    $display("Totals: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/tb_instr_mem.sv ====
// Instruction bus responder
`timescale 1ns/1ps
`default_nettype none

module tb_instr_mem (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_i,
  input  if_cfg_pkg::addr_t  addr_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output if_cfg_pkg::instr_t rdata_o,
  output logic               err_o
);

  logic [31:0]       lfsr;
  int unsigned       cyc;
  int unsigned       gnt_wait;
  int unsigned       resp_delay;
  logic              armed;
  if_cfg_pkg::addr_t head;
  // Granted requests, oldest first, with the cycle they are due
  if_cfg_pkg::addr_t resp_addr [$];
  int unsigned       resp_due  [$];

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // n random bits, one LFSR step per bit
  task automatic draw(input int n, output int unsigned v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  initial begin
    lfsr     = 32'ha853fa9b;
    cyc      = 0;
    gnt_wait = 0;
    armed    = 1'b0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
  end

  ////////////////////////////////////////
  // Accept side
  ////////////////////////////////////////

  // Response due 1 to 3 cycles after the grant cycle
  always @(posedge clk) begin
    if (req_i && gnt_o) begin
      draw(2, resp_delay);
      resp_addr.push_back(addr_i);
      resp_due.push_back(cyc + resp_delay % 3 + 1);
      armed = 1'b0;
    end
    cyc = cyc + 1;
  end

  ////////////////////////////////////////
  // Drive side, on the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin
    rvalid_o = 1'b0;
    // In order, at most one response per cycle
    if (resp_addr.size() > 0 && resp_due[0] <= cyc) begin
      head = resp_addr[0];
      resp_addr.delete(0);
      resp_due.delete(0);
      rvalid_o = 1'b1;
      rdata_o  = head ^ 32'h5a5a_0000;
      // Error region is 0xE000_0000 to 0xEFFF_FFFF
      err_o    = (head[31:28] == 4'he);
    end
    gnt_o = 1'b0;
    if (rst_n && req_i) begin
      // Grant delay 0 to 3 cycles, drawn once per request
      if (!armed) begin
        draw(2, gnt_wait);
        armed = 1'b1;
      end
      if (gnt_wait == 0) begin
        gnt_o = 1'b1;
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset held low for 5 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hw/if_stage.sv ====
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  // Controller
  input  logic                 pc_set_i,
  input  if_ctrl_pkg::pc_mux_e pc_mux_i,
  input  logic                 kill_if_i,
  input  logic                 halt_if_i,
  // Redirect targets
  input  if_cfg_pkg::addr_t    boot_addr_i,
  input  if_cfg_pkg::addr_t    jump_target_i,
  input  if_cfg_pkg::addr_t    branch_target_i,
  input  if_cfg_pkg::addr_t    mepc_i,
  input  if_cfg_pkg::addr_t    dpc_i,
  input  if_cfg_pkg::addr_t    dm_halt_addr_i,
  input  if_cfg_pkg::addr_t    dm_exception_addr_i,
  input  if_cfg_pkg::mtvec_t   mtvec_addr_i,
  input  if_cfg_pkg::irq_id_t  irq_id_i,
  // Instruction bus
  output logic                 instr_req_o,
  output if_cfg_pkg::addr_t    instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  if_cfg_pkg::instr_t   instr_rdata_i,
  input  logic                 instr_err_i,
  // Decode side
  input  logic                 id_ready_i,
  output logic                 instr_valid_o,
  output if_cfg_pkg::addr_t    instr_pc_o,
  output if_cfg_pkg::instr_t   instr_o,
  output logic                 abort_o,
  // Status
  output logic                 if_busy_o,
  output logic                 csr_mtvec_init_o
);

  fetch_push_if u_push_if ();
  fetch_pop_if  u_pop_if ();

  ////////////////////////////////////////
  // Requester, buffer, IF/ID
  ////////////////////////////////////////

  fetch_requester u_requester (
    .clk                 (clk),
    .rst_n               (rst_n),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .boot_addr_i         (boot_addr_i),
    .jump_target_i       (jump_target_i),
    .branch_target_i     (branch_target_i),
    .mepc_i              (mepc_i),
    .dpc_i               (dpc_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .mtvec_addr_i        (mtvec_addr_i),
    .irq_id_i            (irq_id_i),
    .req_o               (instr_req_o),
    .addr_o              (instr_addr_o),
    .gnt_i               (instr_gnt_i),
    .rvalid_i            (instr_rvalid_i),
    .rdata_i             (instr_rdata_i),
    .err_i               (instr_err_i),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .busy_o              (if_busy_o),
    .push                (u_push_if.requester)
  );

  instr_buffer u_buffer (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (u_push_if.buffer),
    .pop   (u_pop_if.buffer)
  );

  // Redirect also clears the IF/ID valid bit
  if_id_stage u_if_id (
    .clk           (clk),
    .rst_n         (rst_n),
    .pop           (u_pop_if.stage),
    .kill_if_i     (kill_if_i),
    .halt_if_i     (halt_if_i),
    .pc_set_i      (pc_set_i),
    .id_ready_i    (id_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_pc_o    (instr_pc_o),
    .instr_o       (instr_o),
    .abort_o       (abort_o)
  );

endmodule

`default_nettype wire

// ==== hw/if_id_stage.sv ====
// IF/ID pipeline register
`timescale 1ns/1ps
`default_nettype none

module if_id_stage (
  input  logic               clk,
  input  logic               rst_n,
  // Head of the instruction buffer
  fetch_pop_if.stage         pop,
  // Controller and decode handshake
  input  logic               kill_if_i,
  input  logic               halt_if_i,
  input  logic               pc_set_i,
  input  logic               id_ready_i,
  // Issued instruction
  output logic               instr_valid_o,
  output if_cfg_pkg::addr_t  instr_pc_o,
  output if_cfg_pkg::instr_t instr_o,
  output logic               abort_o
);

  logic take;

  ////////////////////////////////////////
  // Pop control
  ////////////////////////////////////////

  // Move the head into IF/ID when decode can take it
  // Kill, halt and redirect all keep the buffer untouched
  assign take = pop.valid && id_ready_i && !kill_if_i && !halt_if_i && !pc_set_i;
  assign pop.pop = take;

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_o <= 1'b0;
    end else if (kill_if_i || pc_set_i) begin
      // Wrong-path instruction is dropped
      instr_valid_o <= 1'b0;
    end else if (take) begin
      instr_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      // Decode took it and nothing new follows
      instr_valid_o <= 1'b0;
    end
  end

  // Payload only moves with a pop, so it holds under stall
  always_ff @(posedge clk) begin
    if (take) begin
      instr_pc_o <= pop.addr;
      instr_o    <= pop.instr;
      // Bus error marks the instruction for abort in decode
      abort_o    <= pop.err;
    end
  end

endmodule

`default_nettype wire

// ==== hw/instr_buffer.sv ====
// Instruction buffer
`timescale 1ns/1ps
`default_nettype none

module instr_buffer (
  input  logic        clk,
  input  logic        rst_n,
  fetch_push_if.buffer push,
  fetch_pop_if.buffer  pop
);

  // Entry storage
  if_cfg_pkg::addr_t    addr_mem  [if_cfg_pkg::BUF_DEPTH];
  if_cfg_pkg::instr_t   instr_mem [if_cfg_pkg::BUF_DEPTH];
  logic                 err_mem   [if_cfg_pkg::BUF_DEPTH];

  if_cfg_pkg::buf_cnt_t wr_ptr_q;
  if_cfg_pkg::buf_cnt_t rd_ptr_q;
  if_cfg_pkg::buf_cnt_t count_q;
  logic                 do_push;
  logic                 do_pop;

  // Pointer step with wrap at the last entry
  function automatic if_cfg_pkg::buf_cnt_t ptr_inc(input if_cfg_pkg::buf_cnt_t ptr);
    if (ptr == if_cfg_pkg::BUF_DEPTH - 2'd1) begin
      return '0;
    end else begin
      return ptr + 2'd1;
    end
  endfunction

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Flush wins over both ports
  assign do_push = push.push && !push.flush;
  assign do_pop  = pop.pop && pop.valid && !push.flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (push.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + {1'b0, do_push} - {1'b0, do_pop};
    end
  end

  // Slot reservation count for the requester
  assign push.free_cnt = if_cfg_pkg::BUF_DEPTH - count_q;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr_q]  <= push.push_addr;
      instr_mem[wr_ptr_q] <= push.push_instr;
      err_mem[wr_ptr_q]   <= push.push_err;
    end
  end

  // Head entry straight from storage
  assign pop.valid = (count_q != 2'd0);
  assign pop.addr  = addr_mem[rd_ptr_q];
  assign pop.instr = instr_mem[rd_ptr_q];
  assign pop.err   = err_mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hw/fetch_requester.sv ====
// Fetch requester
`timescale 1ns/1ps
`default_nettype none

module fetch_requester (
  input  logic                 clk,
  input  logic                 rst_n,
  // Redirect from the controller
  input  logic                 pc_set_i,
  input  if_ctrl_pkg::pc_mux_e pc_mux_i,
  input  if_cfg_pkg::addr_t    boot_addr_i,
  input  if_cfg_pkg::addr_t    jump_target_i,
  input  if_cfg_pkg::addr_t    branch_target_i,
  input  if_cfg_pkg::addr_t    mepc_i,
  input  if_cfg_pkg::addr_t    dpc_i,
  input  if_cfg_pkg::addr_t    dm_halt_addr_i,
  input  if_cfg_pkg::addr_t    dm_exception_addr_i,
  input  if_cfg_pkg::mtvec_t   mtvec_addr_i,
  input  if_cfg_pkg::irq_id_t  irq_id_i,
  // Instruction bus
  output logic                 req_o,
  output if_cfg_pkg::addr_t    addr_o,
  input  logic                 gnt_i,
  input  logic                 rvalid_i,
  input  if_cfg_pkg::instr_t   rdata_i,
  input  logic                 err_i,
  // Status
  output logic                 csr_mtvec_init_o,
  output logic                 busy_o,
  // Response write into the buffer
  fetch_push_if.requester      push
);

  if_ctrl_pkg::fetch_state_e state_q;
  if_cfg_pkg::addr_t         target;
  if_cfg_pkg::addr_t         fetch_addr_q;
  if_cfg_pkg::addr_t         hold_addr_q;
  logic                      hold_q;
  if_cfg_pkg::addr_t         q_addr [if_cfg_pkg::MAX_OUTSTANDING];
  if_cfg_pkg::buf_cnt_t      q_cnt_q;
  if_cfg_pkg::buf_cnt_t      stale_cnt_q;
  if_cfg_pkg::buf_cnt_t      out_cnt;
  logic                      can_req;
  logic                      grant;
  logic                      stale_drop;
  logic                      q_push;
  logic                      q_pop;

  ////////////////////////////////////////
  // Next PC select
  ////////////////////////////////////////

  always_comb begin
    target = boot_addr_i;
    case (pc_mux_i)
      if_ctrl_pkg::PC_BOOT:     target = boot_addr_i;
      if_ctrl_pkg::PC_JUMP:     target = jump_target_i;
      if_ctrl_pkg::PC_BRANCH:   target = branch_target_i;
      if_ctrl_pkg::PC_MRET:     target = mepc_i;
      if_ctrl_pkg::PC_DRET:     target = dpc_i;
      // Exceptions share the vector base
      if_ctrl_pkg::PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};
      // Vectored, base plus index times 4
      if_ctrl_pkg::PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      if_ctrl_pkg::PC_TRAP_NMI: target = {mtvec_addr_i, if_cfg_pkg::NMI_INDEX, 2'b00};
      if_ctrl_pkg::PC_TRAP_DBD: target = dm_halt_addr_i;
      if_ctrl_pkg::PC_TRAP_DBE: target = dm_exception_addr_i;
      default:                  target = boot_addr_i;
    endcase
  end

  // mtvec is set up by the CSR file on boot only
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == if_ctrl_pkg::PC_BOOT);

  ////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////

  // Owed responses, valid plus stale
  assign out_cnt = q_cnt_q + stale_cnt_q;
  assign busy_o  = (out_cnt != 2'd0);

  // Request only with a bus slot and a reserved buffer slot
  assign can_req = (out_cnt < if_cfg_pkg::MAX_OUTSTANDING) && (q_cnt_q < push.free_cnt);

  // A request cut off by a redirect is held until granted
  assign req_o  = hold_q || ((state_q == if_ctrl_pkg::FS_FETCH) && can_req);
  assign addr_o = hold_q ? hold_addr_q : fetch_addr_q;
  assign grant  = req_o && gnt_i;

  // Responses from before a redirect go first and are dropped
  assign stale_drop = rvalid_i && (stale_cnt_q != 2'd0);
  assign q_push     = grant && !hold_q && !pc_set_i;
  assign q_pop      = rvalid_i && !stale_drop && !pc_set_i;

  // Write path into the buffer
  assign push.push       = q_pop;
  assign push.push_addr  = q_addr[0];
  assign push.push_instr = rdata_i;
  assign push.push_err   = err_i;
  assign push.flush      = pc_set_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= if_ctrl_pkg::FS_IDLE;
      hold_q      <= 1'b0;
      q_cnt_q     <= '0;
      stale_cnt_q <= '0;
    end else begin
      if (pc_set_i) begin
        state_q     <= if_ctrl_pkg::FS_FETCH;
        q_cnt_q     <= '0;
        // Everything owed so far becomes stale
        stale_cnt_q <= out_cnt + {1'b0, grant} - {1'b0, rvalid_i};
      end else begin
        q_cnt_q     <= q_cnt_q + {1'b0, q_push} - {1'b0, q_pop};
        stale_cnt_q <= stale_cnt_q + {1'b0, grant && hold_q} - {1'b0, stale_drop};
      end
      if (pc_set_i && req_o && !gnt_i) begin
        hold_q <= 1'b1;
      end else if (hold_q && gnt_i) begin
        hold_q <= 1'b0;
      end
    end
  end

  // Fetch address, held request address and granted address queue
  always_ff @(posedge clk) begin
    if (pc_set_i) begin
      fetch_addr_q <= {target[31:2], 2'b00};
    end else if (q_push) begin
      fetch_addr_q <= fetch_addr_q + if_cfg_pkg::PC_STEP;
    end
    if (pc_set_i && req_o && !gnt_i) begin
      hold_addr_q <= addr_o;
    end
    if (q_pop) begin
      q_addr[0] <= q_addr[1];
    end
    if (q_push) begin
      // Slot index is the count left after this cycle's pop
      if ((q_cnt_q == 2'd0) || ((q_cnt_q == 2'd1) && q_pop)) begin
        q_addr[0] <= addr_o;
      end else begin
        q_addr[1] <= addr_o;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_if.sv ====
// Fetch stage internal interfaces
`timescale 1ns/1ps
`default_nettype none

// Requester to buffer, response write path
interface fetch_push_if;

  // One-cycle write strobe with its payload
  logic                 push;
  if_cfg_pkg::addr_t    push_addr;
  if_cfg_pkg::instr_t   push_instr;
  logic                 push_err;
  // One-cycle pulse, empties the buffer
  logic                 flush;
  // Empty slots, seen by the requester for slot reservation
  if_cfg_pkg::buf_cnt_t free_cnt;

  modport requester (
    output push, push_addr, push_instr, push_err, flush,
    input  free_cnt
  );

  modport buffer (
    input  push, push_addr, push_instr, push_err, flush,
    output free_cnt
  );

endinterface

// Buffer to IF/ID register, head entry read path
interface fetch_pop_if;

  // Head entry, valid while the buffer is not empty
  logic               valid;
  if_cfg_pkg::addr_t  addr;
  if_cfg_pkg::instr_t instr;
  logic               err;
  // Consume the head at the next edge when valid
  logic               pop;

  modport buffer (output valid, addr, instr, err, input pop);

  modport stage (input valid, addr, instr, err, output pop);

endinterface

`default_nettype wire

// ==== hw/if_ctrl_pkg.sv ====
// Fetch stage control encodings
package if_ctrl_pkg;

  ////////////////////////////////////////
  // Next-PC select
  ////////////////////////////////////////

  // Redirect source chosen by the controller
  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_DRET     = 4'd4,
    PC_TRAP_EXC = 4'd5,
    PC_TRAP_IRQ = 4'd6,
    PC_TRAP_NMI = 4'd7,
    PC_TRAP_DBD = 4'd8,
    PC_TRAP_DBE = 4'd9
  } pc_mux_e;

  ////////////////////////////////////////
  // Requester FSM
  ////////////////////////////////////////

  // Idle until the first redirect, then fetching for good
  typedef enum logic {
    FS_IDLE  = 1'b0,
    FS_FETCH = 1'b1
  } fetch_state_e;

endpackage

// ==== hw/if_cfg_pkg.sv ====
// Fetch stage configuration
package if_cfg_pkg;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  // Byte address on the instruction bus
  typedef logic [31:0] addr_t;

  // Raw 32-bit instruction word
  typedef logic [31:0] instr_t;

  // Trap vector base, bits 31 to 7 of mtvec
  typedef logic [24:0] mtvec_t;

  // Interrupt index for vectored traps
  typedef logic [4:0]  irq_id_t;

  // Small count, 0 to 3
  // Shared by buffer slots and outstanding fetches
  typedef logic [1:0]  buf_cnt_t;

  ////////////////////////////////////////
  // Sizes and constants
  ////////////////////////////////////////

  // Instruction buffer entries
  localparam buf_cnt_t BUF_DEPTH = 2'd3;

  // Fetches allowed in flight on the bus
  localparam buf_cnt_t MAX_OUTSTANDING = 2'd2;

  // Vector slot taken by an NMI
  localparam irq_id_t NMI_INDEX = 5'd15;

  // Sequential fetch step, one word
  localparam addr_t PC_STEP = 32'd4;

endpackage
